// File: test/daq_patterns.txt
// bank 0 settings words 0-3, then bank 4 bias words 0-3, bias outputs take bits 11:0
// then 17 serial chip words in the low 16 bits, last the protocol error test word
12345679
a5a5c3c1
00ff1234
deadbeef
00000abc
12340fed
00000800
ffff0123
8001 1234 ffff 0000 5a5a a5a5
0f0f f0f0 7e81 c3c3 1111 2222
4444 8888 abcd 0102 fedc
cafe0042

// File: sources.f
src/bus_pkg.sv
src/daq_pkg.sv
src/host_bus_port.sv
src/setting_bank.sv
src/command_bank.sv
src/status_bank.sv
src/serial_readout.sv
src/word_fifo.sv
src/asic_daq_top.sv
test/tb_asic_daq.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_asic_daq -o tb_asic_daq
sim_output=$(./obj_dir/tb_asic_daq || true)
echo "$sim_output"
if grep -q "SIMULATION PASSED" <<< "$sim_output"; then
	exit 0
fi
exit 1

// File: test/tb_asic_daq.sv
`timescale 1ns/10ps

module tb_asic_daq
	import bus_pkg::*;
	import daq_pkg::*;
();

	localparam int clock_period = 20;
	localparam int pattern_count = 26;
	localparam int settings_base = 0; // four bank 0 words
	localparam int bias_base = 4;     // four bank 4 words
	localparam int frame_base = 8;    // seventeen chip words
	localparam int frame_total = 17;
	localparam int first_frames = 8;
	localparam int protocol_index = 25;
	localparam int cycle_budget = 200; // per pattern entry
	localparam int ack_limit = 8;
	localparam logic [7:0] all_done_status8 = 8'b0111_1000; // bits 6 to 3

	logic sysclk;
	logic reset;
	logic register_select;
	logic read;
	logic enable;
	logic [bus_width-1:0] bus_in;
	logic data_a;
	logic [bus_width-1:0] bus_out;
	logic ack_valid;
	logic [7:0] led;
	logic ls_i2c;
	command_pulses_t pulses;
	logic [bias_count-1:0][bias_bits-1:0] bias_words;

	logic [data_width-1:0] patterns [pattern_count];
	logic [15:0] lfsr = 16'd98;
	int pulse_count [4] = '{default: 0}; // indexed by bank 2 offset
	logic [data_width-1:0] value;
	logic [bus_width-1:0] discard;

	asic_daq_top i_dut (.sysclk, .reset, .register_select, .read, .enable, .bus_in, .data_a,
		.bus_out, .ack_valid, .led, .ls_i2c, .pulses, .bias_words);

	initial begin
		sysclk = 1'b0;
		forever #(clock_period / 2) sysclk = ~sysclk;
	end

	// pulses are one cycle wide, so one count per pulse
	always @(negedge sysclk) begin
		if (!reset) begin
			for (int j = 0; j < 4; j++)
				if (pulses[3 - j])
					pulse_count[j]++;
		end
	end

	initial begin
		#(pattern_count * cycle_budget * clock_period);
		$display("watchdog expired, test sequence did not finish in time");
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog");
	end

	// --------------------------------------------------
	task automatic expect_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic bus_transfer(input logic sel, input logic rd, input logic [15:0] data,
		output logic [15:0] result);
		int wait_count; // cycles since the enable cycle
		wait_count = 1;
		@(posedge sysclk);
		#2;
		register_select = sel;
		read = rd;
		bus_in = data;
		enable = 1'b1;
		@(posedge sysclk);
		#2;
		enable = 1'b0;
		do begin
			@(posedge sysclk);
			#1;
			wait_count++;
		end while (!ack_valid && wait_count < ack_limit);
		if (!ack_valid) begin
			$display("no ack_valid within %0d cycles of an enable", ack_limit);
			$display("SIMULATION FAILED");
			$fatal(1, "bus timeout");
		end
		expect_equal("ack latency", 32'd3, 32'(wait_count));
		result = bus_out;
	endtask

	task automatic set_address(input logic [2:0] bank, input logic [3:0] offset);
		logic [15:0] unused;
		bus_transfer(1'b0, 1'b0, {bank, 9'd0, offset}, unused);
	endtask

	task automatic write_word(input logic [31:0] data);
		logic [15:0] unused;
		bus_transfer(1'b1, 1'b0, data[31:16], unused); // high half first
		bus_transfer(1'b1, 1'b0, data[15:0], unused);
	endtask

	task automatic read_word(output logic [31:0] data);
		logic [15:0] high;
		logic [15:0] low;
		bus_transfer(1'b1, 1'b1, 16'd0, high);
		bus_transfer(1'b1, 1'b1, 16'd0, low);
		data = {high, low};
	endtask

	task automatic read_register(input logic [2:0] bank, input logic [3:0] offset,
		output logic [31:0] data);
		set_address(bank, offset);
		read_word(data);
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	task automatic random_bits(input int count, output int result);
		result = 0;
		repeat (count) begin
			lfsr = lfsr_next(lfsr);
			result = (result << 1) | int'(lfsr[0]);
		end
	endtask

	// start bit, then msb first, line low afterwards
	task automatic send_frame(input logic [15:0] word);
		int gap;
		random_bits(3, gap);
		repeat (gap) @(posedge sysclk);
		@(posedge sysclk);
		#2;
		data_a = 1'b1;
		for (int k = frame_bits - 1; k >= 0; k--) begin
			@(posedge sysclk);
			#2;
			data_a = word[k];
		end
		@(posedge sysclk);
		#2;
		data_a = 1'b0;
	endtask

	// --------------------------------------------------
	initial begin
		$readmemh("test/daq_patterns.txt", patterns);
		reset = 1'b1;
		register_select = 1'b0;
		read = 1'b0;
		enable = 1'b0;
		bus_in = '0;
		data_a = 1'b0;
		repeat (2) @(posedge sysclk);
		#2;
		reset = 1'b0;

		// reset state
		read_register(bank_status, 4'd0, value);
		expect_equal("reset status word 0", 32'd0, value);
		read_register(bank_status, 4'd1, value);
		expect_equal("reset trigger count", 32'd0, value);
		read_register(bank_status, 4'd2, value);
		expect_equal("reset fifo_empty", 32'd1, value);
		read_register(bank_status, 4'd4, value);
		expect_equal("reset fifo errors", 32'd0, value);
		expect_equal("reset led", 32'd0, 32'(led));
		expect_equal("reset pulses", 32'd0, 32'(pulses));

		// settings bursts with autoincrement
		set_address(bank_settings, 4'd0);
		for (int i = 0; i < 4; i++)
			write_word(patterns[settings_base + i]);
		set_address(bank_bias, 4'd0);
		for (int i = 0; i < 4; i++)
			write_word(patterns[bias_base + i]);
		set_address(bank_settings, 4'd0);
		for (int i = 0; i < 4; i++) begin
			read_word(value);
			expect_equal($sformatf("settings word %0d", i), patterns[settings_base + i], value);
		end
		set_address(bank_bias, 4'd0);
		for (int i = 0; i < 4; i++) begin
			read_word(value);
			expect_equal($sformatf("bias word %0d", i), patterns[bias_base + i], value);
			expect_equal($sformatf("bias_words %0d", i), 32'(patterns[bias_base + i][11:0]),
				32'(bias_words[i]));
		end
		expect_equal("ls_i2c", 32'(patterns[settings_base][0]), 32'(ls_i2c));

		// command pulses, one per offset
		set_address(bank_pulse, 4'd0);
		for (int i = 0; i < 4; i++) begin
			write_word(32'd0);
			@(negedge sysclk);
			#1;
			for (int j = 0; j < 4; j++)
				expect_equal($sformatf("pulse count %0d after write %0d", j, i),
					(j <= i) ? 32'd1 : 32'd0, 32'(pulse_count[j]));
		end
		repeat (2) begin
			set_address(bank_pulse, 4'd3);
			write_word(32'd0);
		end
		@(negedge sysclk);
		#1;
		expect_equal("trigger pulses", 32'd3, 32'(pulse_count[3]));
		read_register(bank_status, 4'd1, value);
		expect_equal("trigger count", 32'd3, value);
		read_register(bank_status, 4'd0, value);
		expect_equal("done flags", {24'd0, all_done_status8}, value);
		expect_equal("led done flags", 32'(all_done_status8), 32'(led));

		// serial frames back through bank 5
		for (int i = 0; i < first_frames; i++)
			send_frame(patterns[frame_base + i][15:0]);
		repeat (3) @(posedge sysclk); // strobe, then push
		set_address(bank_fifo, 4'd0);
		for (int i = 0; i < first_frames; i++) begin
			read_word(value);
			expect_equal($sformatf("chip word %0d", i), {16'd0, patterns[frame_base + i][15:0]},
				value);
		end
		read_register(bank_status, 4'd2, value);
		expect_equal("fifo_empty after drain", 32'd1, value);

		// fifo underflow, then overflow
		read_register(bank_fifo, 4'd0, value);
		expect_equal("empty pop", 32'd0, value);
		read_register(bank_status, 4'd4, value);
		expect_equal("fifo errors after empty pop", 32'd1, value);
		for (int i = 0; i < frame_total; i++)
			send_frame(patterns[frame_base + i][15:0]);
		repeat (3) @(posedge sysclk);
		read_register(bank_status, 4'd4, value);
		expect_equal("fifo errors after overflow", 32'd2, value);
		set_address(bank_fifo, 4'd0);
		for (int i = 0; i < fifo_depth; i++) begin
			read_word(value);
			expect_equal($sformatf("kept word %0d", i), {16'd0, patterns[frame_base + i][15:0]},
				value);
		end
		read_register(bank_status, 4'd2, value);
		expect_equal("fifo_empty after overflow drain", 32'd1, value);

		// --------------------------------------------------
		// bus protocol errors
		bus_transfer(1'b0, 1'b1, 16'd0, discard);
		read_register(bank_status, 4'd0, value);
		expect_equal("address error", {8'd0, 8'd0, 8'd1, all_done_status8}, value);
		set_address(bank_settings, 4'd5);
		bus_transfer(1'b1, 1'b0, patterns[protocol_index][31:16], discard);
		bus_transfer(1'b1, 1'b1, 16'd0, discard); // read on a half write
		write_word(patterns[protocol_index]);
		read_register(bank_settings, 4'd5, value);
		expect_equal("write after read error", patterns[protocol_index], value);
		read_register(bank_status, 4'd0, value);
		expect_equal("read error", {8'd1, 8'd0, 8'd1, all_done_status8}, value);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: src/asic_daq_top.sv
`timescale 1ns/10ps

module asic_daq_top
	import bus_pkg::*;
	import daq_pkg::*;
(
	input  logic                                 sysclk,
	input  logic                                 reset,
	input  logic                                 register_select,
	input  logic                                 read,
	input  logic                                 enable,
	input  logic [bus_width-1:0]                 bus_in,
	input  logic                                 data_a,
	output logic [bus_width-1:0]                 bus_out,
	output logic                                 ack_valid,
	output logic [7:0]                           led,
	output logic                                 ls_i2c,
	output command_pulses_t                      pulses,
	output logic [bias_count-1:0][bias_bits-1:0] bias_words
);

	reg_access_t access;
	status_t bus_errors;
	logic [data_width-1:0] read_data_word;
	logic [data_width-1:0] settings_rdata;
	logic [data_width-1:0] status_rdata;
	logic [data_width-1:0] bias_rdata;
	logic [data_width-1:0] fifo_rdata;
	logic [bank_words-1:0][data_width-1:0] settings_words;
	logic [bank_words-1:0][data_width-1:0] bias_settings;
	logic [3:0] done_flags;
	logic [trigger_bits-1:0] trigger_count;
	logic word_strobe;
	logic [frame_bits-1:0] chip_word;
	logic fifo_empty;
	logic [fifo_error_bits-1:0] fifo_error_count;

	host_bus_port bus_port (.sysclk, .reset, .register_select, .read, .enable, .bus_in,
		.bus_out, .ack_valid, .access, .read_data_word, .errors(bus_errors));

	// --------------------------------------------------
	// register banks
	setting_bank #(.bank_number(bank_settings)) general_bank (.sysclk, .reset, .access,
		.rdata(settings_rdata), .settings(settings_words));
	setting_bank #(.bank_number(bank_bias)) bias_bank (.sysclk, .reset, .access,
		.rdata(bias_rdata), .settings(bias_settings));
	command_bank commands (.sysclk, .reset, .access, .pulses, .done_flags, .trigger_count);
	status_bank status (.sysclk, .reset, .access, .errors(bus_errors), .done_flags,
		.trigger_count, .fifo_empty, .fifo_error_count, .rdata(status_rdata));

	always_comb begin
		case (access.bank)
			bank_settings: read_data_word = settings_rdata;
			bank_status:   read_data_word = status_rdata;
			bank_bias:     read_data_word = bias_rdata;
			bank_fifo:     read_data_word = fifo_rdata;
			default:       read_data_word = '0; // pulse bank and unused banks
		endcase
	end

	// --------------------------------------------------
	// chip data path
	serial_readout readout (.sysclk, .reset, .data_a, .word_strobe, .data_word(chip_word));
	word_fifo chip_fifo (.sysclk, .reset, .write_enable(word_strobe), .data_in(chip_word),
		.access, .data_out(fifo_rdata), .empty(fifo_empty), .error_count(fifo_error_count));

	assign led = status8_from_done(done_flags);
	assign ls_i2c = settings_words[0][0]; // 0 i2c, 1 ls
	for (genvar i = 0; i < bias_count; i++) begin : g_bias
		assign bias_words[i] = bias_settings[i][bias_bits-1:0];
	end

endmodule

// File: src/word_fifo.sv
`timescale 1ns/10ps

module word_fifo
	import bus_pkg::*;
	import daq_pkg::*;
(
	input  logic                       sysclk,
	input  logic                       reset,
	input  logic                       write_enable,
	input  logic [frame_bits-1:0]      data_in,
	input  reg_access_t                access,
	output logic [data_width-1:0]      data_out,
	output logic                       empty,
	output logic [fifo_error_bits-1:0] error_count
);

	logic [frame_bits-1:0] mem [fifo_depth];
	logic [fifo_log2_depth:0] write_ptr; // one extra wrap bit
	logic [fifo_log2_depth:0] read_ptr;

	wire [fifo_log2_depth:0] occupancy = write_ptr - read_ptr;
	wire full = occupancy == (fifo_log2_depth + 1)'(fifo_depth);
	wire pop = access.read_strobe && access.bank == bank_fifo;
	wire push_ok = write_enable && !full;
	wire push_drop = write_enable && full;
	wire pop_empty = pop && empty;

	assign empty = occupancy == '0;

	always_ff @(posedge sysclk) begin
		if (push_ok)
			mem[write_ptr[fifo_log2_depth-1:0]] <= data_in;
	end

	// --------------------------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			write_ptr <= '0;
			read_ptr <= '0;
			data_out <= '0;
			error_count <= '0;
		end else begin
			if (push_ok)
				write_ptr <= write_ptr + 1'b1;
			if (pop && !empty) begin
				data_out <= data_width'(mem[read_ptr[fifo_log2_depth-1:0]]);
				read_ptr <= read_ptr + 1'b1;
			end else if (pop_empty) begin
				data_out <= '0; // empty pop reads zero
			end
			error_count <= error_count + fifo_error_bits'(push_drop)
				+ fifo_error_bits'(pop_empty);
		end
	end

	pointers_in_range: assert property (@(posedge sysclk) disable iff (reset)
		occupancy <= (fifo_log2_depth + 1)'(fifo_depth));

endmodule

// File: src/serial_readout.sv
`timescale 1ns/10ps

module serial_readout
	import daq_pkg::*;
(
	input  logic                  sysclk,
	input  logic                  reset,
	input  logic                  data_a,
	output logic                  word_strobe,
	output logic [frame_bits-1:0] data_word
);

	logic busy;
	logic [frame_count_bits-1:0] bit_count;

	// --------------------------------------------------
	// idle until a 1 start bit, then frame_bits data bits
	always_ff @(posedge sysclk) begin
		if (reset) begin
			busy <= 1'b0;
			bit_count <= '0;
			word_strobe <= 1'b0;
		end else begin
			word_strobe <= 1'b0;
			if (!busy) begin
				if (data_a) begin
					busy <= 1'b1;
					bit_count <= '0;
				end
			end else begin
				bit_count <= bit_count + 1'b1;
				if (bit_count == frame_count_bits'(frame_bits - 1)) begin
					busy <= 1'b0;
					word_strobe <= 1'b1; // word complete in data_word
				end
			end
		end
	end

	// msb first
	always_ff @(posedge sysclk) begin
		if (busy)
			data_word <= {data_word[frame_bits-2:0], data_a};
	end

endmodule

// File: src/status_bank.sv
`timescale 1ns/10ps

module status_bank
	import bus_pkg::*;
	import daq_pkg::*;
(
	input  logic                       sysclk,
	input  logic                       reset,
	input  reg_access_t                access,
	input  status_t                    errors,
	input  logic [3:0]                 done_flags,
	input  logic [trigger_bits-1:0]    trigger_count,
	input  logic                       fifo_empty,
	input  logic [fifo_error_bits-1:0] fifo_error_count,
	output logic [data_width-1:0]      rdata
);

	status_t word0;

	// bus error counts plus the command done flags
	assign word0 = '{read_errors: errors.read_errors, write_errors: errors.write_errors,
		address_errors: errors.address_errors, status8: status8_from_done(done_flags)};

	always_ff @(posedge sysclk) begin
		if (reset) begin
			rdata <= '0;
		end else if (access.read_strobe && access.bank == bank_status) begin
			case (access.offset)
				4'd0: rdata <= word0;
				4'd1: rdata <= data_width'(trigger_count);
				4'd2: rdata <= data_width'(fifo_empty);
				4'd4: rdata <= data_width'(fifo_error_count);
				default: rdata <= '0; // spare words
			endcase
		end
	end

endmodule

// File: src/command_bank.sv
`timescale 1ns/10ps

module command_bank
	import bus_pkg::*;
	import daq_pkg::*;
(
	input  logic                    sysclk,
	input  logic                    reset,
	input  reg_access_t             access,
	output command_pulses_t         pulses,
	output logic [3:0]              done_flags,
	output logic [trigger_bits-1:0] trigger_count
);

	logic [3:0] request; // decoded write, one bit per command

	wire command_write = access.write_strobe && access.bank == bank_pulse
		&& access.offset < 4'd4;

	always_ff @(posedge sysclk) begin
		if (reset) begin
			request <= '0;
			pulses <= '0;
			done_flags <= '0;
			trigger_count <= '0;
		end else begin
			request <= '0;
			if (command_write)
				request[access.offset[1:0]] <= 1'b1;
			pulses <= '{dreset: request[0], serial_load: request[1],
				i2c_start: request[2], trigger: request[3]};
			done_flags <= done_flags | request; // sticky until reset
			if (request[3])
				trigger_count <= trigger_count + 1'b1; // wraps
		end
	end

	// --------------------------------------------------
	pulses_onehot: assert property (@(posedge sysclk) disable iff (reset)
		$onehot0(pulses));

	pulses_single_cycle: assert property (@(posedge sysclk) disable iff (reset)
		(|pulses) |=> (pulses == '0));

endmodule

// File: src/setting_bank.sv
`timescale 1ns/10ps

module setting_bank
	import bus_pkg::*;
#(
	parameter logic [bank_bits-1:0] bank_number = bank_settings
) (
	input  logic                                  sysclk,
	input  logic                                  reset,
	input  reg_access_t                           access,
	output logic [data_width-1:0]                 rdata,
	output logic [bank_words-1:0][data_width-1:0] settings
);

	wire selected = access.bank == bank_number;

	// --------------------------------------------------
	// write side, words show on settings right away
	always_ff @(posedge sysclk) begin
		if (reset) begin
			settings <= '0;
		end else if (selected && access.write_strobe) begin
			settings[access.offset] <= access.wdata;
		end
	end

	// registered readback
	always_ff @(posedge sysclk) begin
		if (reset) begin
			rdata <= '0;
		end else if (selected && access.read_strobe) begin
			rdata <= settings[access.offset];
		end
	end

endmodule

// File: src/host_bus_port.sv
`timescale 1ns/10ps

module host_bus_port
	import bus_pkg::*;
	import daq_pkg::*;
(
	input  logic                  sysclk,
	input  logic                  reset,
	input  logic                  register_select, // 0 address, 1 data
	input  logic                  read,
	input  logic                  enable,
	input  logic [bus_width-1:0]  bus_in,
	output logic [bus_width-1:0]  bus_out,
	output logic                  ack_valid,
	output reg_access_t           access,
	input  logic [data_width-1:0] read_data_word,
	output status_t               errors
);

	logic [bus_width-1:0] address_reg;
	logic [bus_width-1:0] write_high;
	logic [data_width-1:0] read_word;
	logic write_half; // high half of a write is held
	logic read_half;  // high half of a read went out
	logic [1:0] ack_pipe;
	logic [1:0] load_high_pipe;
	logic [1:0] load_low_pipe;
	logic [error_count_bits-1:0] read_errors;
	logic [error_count_bits-1:0] write_errors;
	logic [error_count_bits-1:0] address_errors;

	function automatic logic [error_count_bits-1:0] sat_inc(input logic [error_count_bits-1:0] c);
		return (&c) ? c : c + 1'b1;
	endfunction

	wire address_access = enable && !register_select;
	wire data_write = enable && register_select && !read;
	wire data_read = enable && register_select && read;
	wire write_first = data_write && !read_half && !write_half;
	wire write_second = data_write && !read_half && write_half;
	wire read_first = data_read && !write_half && !read_half;
	wire read_second = data_read && !write_half && read_half;

	// --------------------------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			address_reg <= '0;
			write_half <= 1'b0;
			read_half <= 1'b0;
			access <= '0;
			ack_pipe <= '0;
			load_high_pipe <= '0;
			load_low_pipe <= '0;
			ack_valid <= 1'b0;
			read_errors <= '0;
			write_errors <= '0;
			address_errors <= '0;
		end else begin
			access.write_strobe <= write_second;
			access.read_strobe <= read_first;
			ack_pipe <= {ack_pipe[0], enable}; // ack lands 3 cycles after enable
			load_high_pipe <= {load_high_pipe[0], read_first};
			load_low_pipe <= {load_low_pipe[0], read_second};
			ack_valid <= ack_pipe[1];
			if (address_access) begin
				write_half <= 1'b0;
				read_half <= 1'b0;
				if (read)
					address_errors <= sat_inc(address_errors);
				else
					address_reg <= bus_in;
			end
			if (data_write && read_half) begin
				write_errors <= sat_inc(write_errors); // drop the read pair
				read_half <= 1'b0;
			end
			if (data_read && write_half) begin
				read_errors <= sat_inc(read_errors);
				write_half <= 1'b0;
			end
			if (write_first)
				write_half <= 1'b1;
			if (read_first)
				read_half <= 1'b1;
			if (write_first || read_first) begin
				access.bank <= address_reg[bus_width-1 -: bank_bits];
				access.offset <= address_reg[offset_bits-1:0];
			end
			if (write_second) begin
				access.bank <= address_reg[bus_width-1 -: bank_bits];
				access.offset <= address_reg[offset_bits-1:0];
				access.wdata <= {write_high, bus_in};
				write_half <= 1'b0;
			end
			if (read_second)
				read_half <= 1'b0;
			if (write_second || read_second)
				address_reg[offset_bits-1:0] <= address_reg[offset_bits-1:0] + 1'b1;
		end
	end

	// held data halves
	always_ff @(posedge sysclk) begin
		if (write_first)
			write_high <= bus_in;
		if (load_high_pipe[1]) begin
			read_word <= read_data_word;
			bus_out <= read_data_word[data_width-1 -: bus_width];
		end else if (load_low_pipe[1]) begin
			bus_out <= read_word[bus_width-1:0];
		end
	end

	assign errors = '{read_errors: read_errors, write_errors: write_errors,
		address_errors: address_errors, status8: 8'd0};

	// ack pipeline only holds one transaction at a time
	enable_spacing: assert property (@(posedge sysclk) disable iff (reset)
		enable |=> !enable [*3]);

endmodule

// File: src/daq_pkg.sv
package daq_pkg;

	localparam int error_count_bits = 8; // bus protocol error counters
	localparam int trigger_bits = 8;
	localparam int fifo_log2_depth = 4;
	localparam int fifo_depth = 1 << fifo_log2_depth;
	localparam int fifo_error_bits = 24;
	localparam int frame_bits = 16; // one chip word
	localparam int frame_count_bits = $clog2(frame_bits);
	localparam int bias_count = 4;
	localparam int bias_bits = 12;

	// command n sits at bank 2 offset n
	typedef struct packed {
		logic dreset;      // offset 0
		logic serial_load; // offset 1
		logic i2c_start;   // offset 2
		logic trigger;     // offset 3
	} command_pulses_t;

	// status word 0
	typedef struct packed {
		logic [error_count_bits-1:0] read_errors;
		logic [error_count_bits-1:0] write_errors;
		logic [error_count_bits-1:0] address_errors;
		logic [7:0]                  status8;
	} status_t;

	// done flag n belongs to command n
	function automatic logic [7:0] status8_from_done(input logic [3:0] done);
		return {1'b0, done[0], done[1], done[2], done[3], 3'b000};
	endfunction

endpackage

// File: src/bus_pkg.sv
package bus_pkg;

	// host bus geometry
	localparam int bus_width = 16;
	localparam int data_width = 32; // two bus transactions
	localparam int bank_bits = 3;
	localparam int offset_bits = 4;
	localparam int bank_words = 1 << offset_bits;

	// --------------------------------------------------
	// bank map, 3 and 6 and 7 unused
	localparam logic [bank_bits-1:0] bank_settings = 3'd0;
	localparam logic [bank_bits-1:0] bank_status   = 3'd1;
	localparam logic [bank_bits-1:0] bank_pulse    = 3'd2;
	localparam logic [bank_bits-1:0] bank_bias     = 3'd4;
	localparam logic [bank_bits-1:0] bank_fifo     = 3'd5;

	// --------------------------------------------------
	// one register access as seen by every bank
	typedef struct packed {
		logic                   spare;        // keeps the struct at 42 bits
		logic [bank_bits-1:0]   bank;
		logic [offset_bits-1:0] offset;
		logic                   write_strobe; // one cycle
		logic                   read_strobe;  // one cycle
		logic [data_width-1:0]  wdata;
	} reg_access_t;

endpackage
